//--- all.f
mips_pkg.sv
decode_if.sv
instr_decode.sv
phase_ctrl.sv
reg_file.sv
alu.sv
mips_core.sv
tb_checker.sv
tb_mips_core.sv

//--- tb_mips_core.sv
// testbench top: clock, reset, program table, instruction memory responder and watchdog
module tb_mips_core import mips_pkg::*; ();

    localparam int CLK_PERIOD   = 8;
    localparam int INSTR_CYCLES = 16;   // slowest fetch plus two exec cycles is 12
    localparam int SEED         = 11720;

    logic              clk;
    logic              rst_n;
    logic              imem_req;
    logic [31:0]       imem_addr;
    logic              imem_ack;
    logic [31:0]       imem_rdata;
    logic              wb_en;
    logic [4:0]        wb_idx;
    logic [31:0]       wb_data;
    logic [63:0][31:0] prog;            // program table, one word per entry
    logic              ready;
    logic              done;
    int                errors;
    int                fetch_count;

    function automatic logic [31:0] rtype_word(logic [5:0] fn, logic [4:0] rd,
                                               logic [4:0] rs, logic [4:0] rt, logic [4:0] sa);
        return {OP_RTYPE, rs, rt, rd, sa, fn};
    endfunction

    function automatic logic [31:0] itype_word(logic [5:0] op, logic [4:0] rt,
                                               logic [4:0] rs, logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] jump_word(logic [5:0] op, int index);
        return {op, index[25:0]};
    endfunction

    mips_core DUT (.*);

    tb_checker u_check (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        rst_n      = 1'b0;
        imem_ack   = 1'b0;
        imem_rdata = '0;
        prog       = '0;
        prog[0]  = itype_word(OP_ADDI,  5'd1,  5'd0, 16'h0005);
        prog[1]  = itype_word(OP_ADDI,  5'd2,  5'd0, 16'hfffd);    // sign-extended -3
        prog[2]  = itype_word(OP_ORI,   5'd3,  5'd0, 16'h8001);    // zero-extended
        prog[3]  = itype_word(OP_ANDI,  5'd4,  5'd2, 16'hff0f);
        prog[4]  = itype_word(OP_XORI,  5'd5,  5'd2, 16'h8000);
        prog[5]  = itype_word(OP_LUI,   5'd6,  5'd0, 16'h1234);
        prog[6]  = rtype_word(FN_ADD,   5'd7,  5'd1, 5'd2, 5'd0);
        prog[7]  = rtype_word(FN_ADDU,  5'd8,  5'd6, 5'd3, 5'd0);
        prog[8]  = rtype_word(FN_SUBU,  5'd9,  5'd1, 5'd2, 5'd0);
        prog[9]  = rtype_word(FN_AND,   5'd10, 5'd6, 5'd5, 5'd0);
        prog[10] = rtype_word(FN_OR,    5'd11, 5'd1, 5'd3, 5'd0);
        prog[11] = rtype_word(FN_XOR,   5'd12, 5'd2, 5'd1, 5'd0);
        prog[12] = rtype_word(FN_SLT,   5'd13, 5'd2, 5'd1, 5'd0);
        prog[13] = rtype_word(FN_SLTU,  5'd14, 5'd2, 5'd1, 5'd0);
        prog[14] = itype_word(OP_SLTI,  5'd15, 5'd2, 16'hfffe);
        prog[15] = itype_word(OP_SLTIU, 5'd16, 5'd1, 16'hffff);
        prog[16] = rtype_word(FN_SLL,   5'd17, 5'd0, 5'd3, 5'd4);
        prog[17] = rtype_word(FN_SRL,   5'd18, 5'd0, 5'd2, 5'd8);
        prog[18] = rtype_word(FN_SRA,   5'd19, 5'd0, 5'd2, 5'd1);
        prog[19] = rtype_word(FN_SLLV,  5'd20, 5'd1, 5'd1, 5'd0);  // amount from r1
        prog[20] = rtype_word(FN_SRLV,  5'd21, 5'd1, 5'd2, 5'd0);
        prog[21] = rtype_word(FN_SRAV,  5'd22, 5'd1, 5'd2, 5'd0);
        prog[22] = itype_word(OP_ADDI,  5'd0,  5'd1, 16'h0007);    // r0 write, pulse only
        prog[23] = rtype_word(FN_ADD,   5'd23, 5'd0, 5'd1, 5'd0);
        prog[24] = itype_word(OP_BEQ,   5'd1,  5'd1, 16'h0001);    // taken
        prog[25] = itype_word(OP_ADDI,  5'd24, 5'd0, 16'h0099);
        prog[26] = itype_word(OP_BNE,   5'd1,  5'd1, 16'h0001);    // not taken
        prog[27] = itype_word(OP_BNE,   5'd2,  5'd1, 16'h0001);    // taken
        prog[28] = itype_word(OP_ADDI,  5'd24, 5'd0, 16'h0098);
        prog[29] = itype_word(OP_BEQ,   5'd2,  5'd1, 16'h0002);    // not taken
        prog[30] = itype_word(OP_LW,    5'd25, 5'd0, 16'h0000);
        prog[31] = itype_word(OP_SW,    5'd1,  5'd0, 16'h0004);
        prog[32] = rtype_word(FN_MULT,  5'd0,  5'd1, 5'd2, 5'd0);
        prog[33] = rtype_word(FN_DIV,   5'd0,  5'd1, 5'd2, 5'd0);
        prog[34] = rtype_word(FN_MTHI,  5'd0,  5'd1, 5'd0, 5'd0);
        prog[35] = jump_word(OP_JAL, 40);
        prog[36] = jump_word(OP_J, 44);                             // return point of jr
        prog[37] = itype_word(OP_ADDI,  5'd24, 5'd0, 16'h0097);
        prog[40] = itype_word(OP_ADDI,  5'd26, 5'd1, 16'h0040);
        prog[41] = rtype_word(FN_JR,    5'd0,  5'd31, 5'd0, 5'd0);
        prog[42] = itype_word(OP_ADDI,  5'd24, 5'd0, 16'h0096);
        prog[44] = itype_word(OP_ADDI,  5'd27, 5'd26, 16'hffff);
        prog[45] = rtype_word(FN_OR,    5'd28, 5'd27, 5'd23, 5'd0);
        prog[46] = jump_word(OP_J, 46);                             // halt loop
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        wait (done);
        repeat (4) @(posedge clk);
        $display("run finished: %0d fetches, %0d errors", fetch_count, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    // four-phase memory side, random wait before each ack
    initial begin : responder
        int unsigned delay;
        int unsigned idx;
        delay = $urandom(SEED);
        forever begin
            @(posedge clk);
            if (rst_n && imem_req && !imem_ack) begin
                delay = $urandom_range(5, 0);
                repeat (delay) @(posedge clk);
                idx = imem_addr >> 2;
                imem_rdata <= (idx < 64) ? prog[idx] : 32'h0000_0000;
                imem_ack   <= 1'b1;
                do @(posedge clk); while (imem_req);     // rdata held until the next req
                imem_ack   <= 1'b0;
            end
        end
    end

    initial begin : watchdog
        wait (ready);
        #(fetch_count * INSTR_CYCLES * CLK_PERIOD + 20 * CLK_PERIOD);
        $display("run did not finish, the program end was not reached in time");
        $display("run finished: %0d fetches, %0d errors", fetch_count, errors + 1);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

//--- tb_checker.sv
// reference model of the program that checks the fetch order and every write-back
module tb_checker import mips_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              imem_req,
    input  logic [31:0]       imem_addr,
    input  logic              wb_en,
    input  logic [4:0]        wb_idx,
    input  logic [31:0]       wb_data,
    input  logic [63:0][31:0] prog,
    output logic              ready,
    output logic              done,
    output int                errors,
    output int                fetch_count
);

    logic [31:0] exp_addr [$];      // expected fetch addresses ending with the halt
    logic [4:0]  exp_idx [$];
    logic [31:0] exp_data [$];
    logic [31:0] model [32];
    logic        req_q;
    logic        rst_q;

    function automatic logic [31:0] word_at(logic [31:0] addr);
        return (addr[31:2] < 64) ? prog[addr[31:2]] : 32'h0;   // nop past the table
    endfunction

    task automatic compare_value(string name, logic [31:0] got, logic [31:0] want);
        if (got !== want) begin
            errors++;
            $display("mismatch %s: got 0x%08h, expected 0x%08h", name, got, want);
        end
    endtask

    // steps through the program and records every fetch and write-back
    task automatic run_model();
        logic [31:0] pc, w, a, b, simm, res, nxt;
        logic [4:0]  dst;
        logic        wr;
        pc = RESET_PC;
        for (int i = 0; i < 32; i++) begin
            model[i] = '0;
        end
        for (int n = 0; n < 200; n++) begin
            w   = word_at(pc);
            nxt = pc + 32'd4;
            exp_addr.push_back(pc);
            if ((w[31:26] == OP_J) && ({nxt[31:28], w[25:0], 2'b00} == pc)) begin
                break;                                  // jump to itself ends the program
            end
            a    = model[w[25:21]];
            b    = model[w[20:16]];
            simm = {{16{w[15]}}, w[15:0]};
            dst  = w[20:16];
            wr   = 1'b1;
            res  = '0;
            case (w[31:26])
                OP_RTYPE: begin
                    dst = w[15:11];
                    case (w[5:0])
                        FN_ADD, FN_ADDU: res = a + b;
                        FN_SUBU: res = a - b;
                        FN_AND:  res = a & b;
                        FN_OR:   res = a | b;
                        FN_XOR:  res = a ^ b;
                        FN_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        FN_SLTU: res = (a < b) ? 32'd1 : 32'd0;
                        FN_SLL:  res = b << w[10:6];
                        FN_SRL:  res = b >> w[10:6];
                        FN_SRA:  res = $signed(b) >>> w[10:6];
                        FN_SLLV: res = b << a[4:0];
                        FN_SRLV: res = b >> a[4:0];
                        FN_SRAV: res = $signed(b) >>> a[4:0];
                        FN_JR: begin
                            wr  = 1'b0;
                            nxt = a;
                        end
                        default: wr = 1'b0;             // mult, div and hi/lo moves
                    endcase
                end
                OP_J: begin
                    wr  = 1'b0;
                    nxt = {nxt[31:28], w[25:0], 2'b00};
                end
                OP_JAL: begin
                    dst = LINK_REG;
                    res = pc + 32'd4;
                    nxt = {nxt[31:28], w[25:0], 2'b00};
                end
                OP_BEQ, OP_BNE: begin
                    wr = 1'b0;
                    if ((a == b) == (w[31:26] == OP_BEQ)) begin
                        nxt = nxt + (simm << 2);
                    end
                end
                OP_ADDI, OP_ADDIU: res = a + simm;
                OP_SLTI:  res = ($signed(a) < $signed(simm)) ? 32'd1 : 32'd0;
                OP_SLTIU: res = (a < simm) ? 32'd1 : 32'd0;
                OP_ANDI:  res = a & {16'h0000, w[15:0]};
                OP_ORI:   res = a | {16'h0000, w[15:0]};
                OP_XORI:  res = a ^ {16'h0000, w[15:0]};
                OP_LUI:   res = {w[15:0], 16'h0000};
                default:  wr = 1'b0;                    // loads and stores
            endcase
            if (wr) begin
                exp_idx.push_back(dst);
                exp_data.push_back(res);
                if (dst != 5'd0) begin
                    model[dst] = res;
                end
            end
            pc = nxt;
        end
        fetch_count = exp_addr.size();
    endtask

    initial begin
        ready       = 1'b0;
        done        = 1'b0;
        errors      = 0;
        fetch_count = 0;
        @(posedge clk);             // program table is loaded at time zero
        run_model();
        ready = 1'b1;
    end

    always @(posedge clk) begin
        if (!rst_n) begin
            req_q <= 1'b0;
            rst_q <= 1'b0;
        end else if (ready && !done) begin
            if (!rst_q) begin                           // first edge after reset release
                if (imem_req !== 1'b0 || wb_en !== 1'b0) begin
                    errors++;
                    $display("imem_req or wb_en is not low when reset ends");
                end
            end
            if (imem_req && !req_q) begin               // rising req starts a fetch
                if (exp_addr.size() == 0) begin
                    errors++;
                    $display("fetch at 0x%08h after the end of the program", imem_addr);
                end else begin
                    compare_value("imem_addr", imem_addr, exp_addr.pop_front());
                    if (exp_addr.size() == 0) begin
                        if (exp_idx.size() != 0) begin
                            errors += exp_idx.size();
                            $display("%0d write-backs missing at program end", exp_idx.size());
                        end
                        done = 1'b1;
                    end
                end
            end
            if (wb_en) begin
                if (exp_idx.size() == 0) begin
                    errors++;
                    $display("extra write-back to register %0d", wb_idx);
                end else begin
                    compare_value("wb_idx", {27'd0, wb_idx}, {27'd0, exp_idx.pop_front()});
                    compare_value("wb_data", wb_data, exp_data.pop_front());
                end
            end
            req_q <= imem_req;
            rst_q <= 1'b1;
        end
    end

endmodule

//--- mips_core.sv
// mips core top: multicycle integer core with a req/ack instruction port
module mips_core (
    input  logic        clk,
    input  logic        rst_n,
    output logic        imem_req,
    output logic [31:0] imem_addr,
    input  logic        imem_ack,
    input  logic [31:0] imem_rdata,
    output logic        wb_en,
    output logic [4:0]  wb_idx,
    output logic [31:0] wb_data
);

    logic        exec1;
    logic        exec2;
    logic        taken;
    logic [31:0] pc_plus4;
    logic [31:0] rs_data;
    logic [31:0] rt_data;

    decode_if dec_bus ();

    instr_decode u_decode (
        .clk   (clk),
        .rst_n (rst_n),
        .exec1 (exec1),
        .exec2 (exec2),
        .instr (imem_rdata),    // memory holds the word through exec1
        .dec   (dec_bus.producer)
    );

    phase_ctrl u_ctrl (
        .clk       (clk),
        .rst_n     (rst_n),
        .imem_ack  (imem_ack),
        .imem_req  (imem_req),
        .imem_addr (imem_addr),
        .exec1     (exec1),
        .exec2     (exec2),
        .pc_plus4  (pc_plus4),
        .taken     (taken),
        .rs_data   (rs_data),
        .dec       (dec_bus.consumer)
    );

    reg_file u_regs (
        .clk     (clk),
        .rst_n   (rst_n),
        .dec     (dec_bus.consumer),
        .exec2   (exec2),
        .wb_data (wb_data),
        .rs_data (rs_data),
        .rt_data (rt_data)
    );

    alu u_alu (
        .dec      (dec_bus.consumer),
        .rs_data  (rs_data),
        .rt_data  (rt_data),
        .pc_plus4 (pc_plus4),
        .wb_data  (wb_data),
        .taken    (taken)
    );

    // write-back observation port
    assign wb_en  = dec_bus.wr_en;
    assign wb_idx = dec_bus.dest_idx;

endmodule

//--- alu.sv
// alu: write-back value and branch decision for each instruction code
module alu import mips_pkg::*; (
    decode_if.consumer  dec,
    input  logic [31:0] rs_data,
    input  logic [31:0] rt_data,
    input  logic [31:0] pc_plus4,
    output logic [31:0] wb_data,
    output logic        taken
);

    logic        use_imm;
    logic [31:0] op_b;
    logic [4:0]  sh;

    // immediate forms take imm as second operand
    assign use_imm = dec.instr_code inside {ADDI, ADDIU, ANDI, ORI, XORI, SLTI, SLTIU, LUI};
    assign op_b    = use_imm ? dec.imm : rt_data;

    // variable shifts take the amount from rs
    assign sh = (dec.instr_code inside {SLLV, SRLV, SRAV}) ? rs_data[4:0] : dec.shamt;

    always_comb begin
        case (dec.instr_code)
            ADD, ADDU, ADDI, ADDIU: wb_data = rs_data + op_b;
            SUBU:                   wb_data = rs_data - op_b;
            AND, ANDI:              wb_data = rs_data & op_b;
            OR, ORI:                wb_data = rs_data | op_b;
            XOR, XORI:              wb_data = rs_data ^ op_b;
            SLT, SLTI: begin
                wb_data = {31'd0, $signed(rs_data) < $signed(op_b)};
            end
            SLTU, SLTIU: begin
                wb_data = {31'd0, rs_data < op_b};   // unsigned compare
            end
            SLL, SLLV:              wb_data = op_b << sh;
            SRL, SRLV:              wb_data = op_b >> sh;
            SRA, SRAV:              wb_data = $unsigned($signed(op_b) >>> sh);
            LUI:                    wb_data = {op_b[15:0], 16'h0000};
            JAL, BGEZAL, BLTZAL:    wb_data = pc_plus4;     // return address
            default:                wb_data = 32'd0;
        endcase
    end

    // only beq/bne redirect the pc through taken
    always_comb begin
        case (dec.instr_code)
            BEQ:     taken = (rs_data == rt_data);
            BNE:     taken = (rs_data != rt_data);
            default: taken = 1'b0;
        endcase
    end

endmodule

//--- reg_file.sv
// register file with 32 words of 32 bits, two combinational reads and one write port
module reg_file (
    input  logic        clk,
    input  logic        rst_n,
    decode_if.consumer  dec,
    input  logic        exec2,
    input  logic [31:0] wb_data,
    output logic [31:0] rs_data,
    output logic [31:0] rt_data
);

    logic [31:0] regs [32];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (exec2 && dec.wr_en && (dec.dest_idx != 5'd0)) begin
            regs[dec.dest_idx] <= wb_data;      // r0 writes dropped here
        end
    end

    // r0 is cleared at reset and never written, so it reads zero
    assign rs_data = regs[dec.rs_idx];
    assign rt_data = regs[dec.rt_idx];

    // decoder write enable must line up with the controller's exec2
    a_wr_in_exec2: assert property (@(posedge clk) disable iff (!rst_n)
        dec.wr_en |-> exec2)
        else $error("register write outside exec2");

endmodule

//--- phase_ctrl.sv
// phase controller: fetch/exec FSM, pc register, imem four-phase handshake, next pc
module phase_ctrl import mips_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        imem_ack,
    output logic        imem_req,
    output logic [31:0] imem_addr,
    output logic        exec1,
    output logic        exec2,
    output logic [31:0] pc_plus4,
    input  logic        taken,
    input  logic [31:0] rs_data,
    decode_if.consumer  dec
);

    phase_t      phase;
    logic [31:0] pc;
    logic [31:0] next_pc;
    logic        req_done;      // req dropped, waiting for ack to clear

    assign imem_addr = pc;      // held for the whole fetch
    assign pc_plus4  = pc + 32'd4;
    assign exec1     = (phase == EXEC1);
    assign exec2     = (phase == EXEC2);

    // no delay slot, branch offset counts from pc+4
    always_comb begin
        if (taken) begin
            next_pc = pc_plus4 + {dec.imm[29:0], 2'b00};
        end else if (dec.instr_code inside {J, JAL}) begin
            next_pc = {pc_plus4[31:28], dec.target, 2'b00};
        end else if (dec.instr_code == JR) begin
            next_pc = rs_data;
        end else begin
            next_pc = pc_plus4;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase    <= FETCH;
            pc       <= RESET_PC;
            imem_req <= 1'b0;
            req_done <= 1'b0;
        end else begin
            case (phase)
                FETCH: begin
                    if (req_done) begin
                        if (!imem_ack) begin         // handshake closed, word still held
                            req_done <= 1'b0;
                            phase    <= EXEC1;
                        end
                    end else if (imem_req) begin
                        if (imem_ack) begin
                            imem_req <= 1'b0;
                            req_done <= 1'b1;
                        end
                    end else if (!imem_ack) begin
                        imem_req <= 1'b1;
                    end
                end
                EXEC1: phase <= EXEC2;
                EXEC2: begin
                    pc    <= next_pc;
                    phase <= FETCH;
                end
                default: phase <= FETCH;
            endcase
        end
    end

    // memory side of the handshake sees req held until it acks
    a_req_held: assert property (@(posedge clk) disable iff (!rst_n)
        (imem_req && !imem_ack) |=> imem_req)
        else $error("imem_req dropped before imem_ack");

endmodule

//--- instr_decode.sv
// instruction decoder: holds the fetched word and splits it into fields and a code
module instr_decode import mips_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        exec1,
    input  logic        exec2,
    input  logic [31:0] instr,
    decode_if.producer  dec
);

    logic [31:0] saved_instr;
    logic [31:0] word;
    logic [5:0]  opcode;
    logic [5:0]  funct;
    logic [4:0]  rt_sel;
    logic        r_type;
    logic        j_type;
    instr_code_t code;
    logic        writes;

    // instruction register, loaded while memory still drives the word
    always_ff @(posedge clk) begin
        if (exec1) begin
            saved_instr <= instr;
        end
    end

    assign word   = exec1 ? instr : saved_instr;   // live word only in exec1
    assign opcode = word[31:26];
    assign funct  = word[5:0];
    assign rt_sel = word[20:16];
    assign r_type = (opcode == OP_RTYPE);
    assign j_type = (opcode == OP_J) || (opcode == OP_JAL);

    // opcode / function to instruction code
    always_comb begin
        case (opcode)
            OP_RTYPE: begin
                case (funct)
                    FN_ADD:   code = ADD;
                    FN_ADDU:  code = ADDU;
                    FN_SUBU:  code = SUBU;
                    FN_AND:   code = AND;
                    FN_OR:    code = OR;
                    FN_XOR:   code = XOR;
                    FN_SLT:   code = SLT;
                    FN_SLTU:  code = SLTU;
                    FN_SLL:   code = SLL;
                    FN_SLLV:  code = SLLV;
                    FN_SRL:   code = SRL;
                    FN_SRLV:  code = SRLV;
                    FN_SRA:   code = SRA;
                    FN_SRAV:  code = SRAV;
                    FN_JR:    code = JR;
                    FN_JALR:  code = JALR;
                    FN_MFHI:  code = MFHI;
                    FN_MTHI:  code = MTHI;
                    FN_MFLO:  code = MFLO;
                    FN_MTLO:  code = MTLO;
                    FN_MULT:  code = MULT;
                    FN_MULTU: code = MULTU;
                    FN_DIV:   code = DIV;
                    FN_DIVU:  code = DIVU;
                    default:  code = NOP;
                endcase
            end
            OP_REGIMM: begin
                case (rt_sel)
                    RT_BLTZ:   code = BLTZ;
                    RT_BGEZ:   code = BGEZ;
                    RT_BLTZAL: code = BLTZAL;
                    RT_BGEZAL: code = BGEZAL;
                    default:   code = NOP;
                endcase
            end
            OP_J:     code = J;
            OP_JAL:   code = JAL;
            OP_BEQ:   code = BEQ;
            OP_BNE:   code = BNE;
            OP_BLEZ:  code = BLEZ;
            OP_BGTZ:  code = BGTZ;
            OP_ADDI:  code = ADDI;
            OP_ADDIU: code = ADDIU;
            OP_SLTI:  code = SLTI;
            OP_SLTIU: code = SLTIU;
            OP_ANDI:  code = ANDI;
            OP_ORI:   code = ORI;
            OP_XORI:  code = XORI;
            OP_LUI:   code = LUI;
            OP_LB:    code = LB;
            OP_LH:    code = LH;
            OP_LWL:   code = LWL;
            OP_LW:    code = LW;
            OP_LBU:   code = LBU;
            OP_LHU:   code = LHU;
            OP_LWR:   code = LWR;
            OP_SB:    code = SB;
            OP_SH:    code = SH;
            OP_SW:    code = SW;
            default:  code = NOP;
        endcase
    end

    // field split by format
    always_comb begin
        dec.rs_idx   = '0;
        dec.rt_idx   = '0;
        dec.dest_idx = '0;
        dec.shamt    = '0;
        dec.imm      = '0;
        dec.target   = '0;
        if (r_type) begin
            dec.rs_idx   = word[25:21];
            dec.rt_idx   = word[20:16];
            dec.dest_idx = word[15:11];
            dec.shamt    = word[10:6];
        end else if (j_type) begin
            dec.target = word[25:0];
            if (code == JAL) begin
                dec.dest_idx = LINK_REG;
            end
        end else begin
            dec.rs_idx = word[25:21];
            dec.rt_idx = word[20:16];    // compare operand for beq/bne
            if (code inside {BGEZAL, BLTZAL}) begin
                dec.dest_idx = LINK_REG;
            end else begin
                dec.dest_idx = word[20:16];
            end
            if (code inside {ANDI, ORI, XORI}) begin
                dec.imm = {16'h0000, word[15:0]};           // logical ops zero-extend
            end else begin
                dec.imm = {{16{word[15]}}, word[15:0]};
            end
        end
    end

    // loads, jr, hi/lo traffic and unknown words never write
    always_comb begin
        case (code)
            ADD, ADDU, SUBU, AND, OR, XOR, SLT, SLTU,
            SLL, SLLV, SRL, SRLV, SRA, SRAV,
            ADDI, ADDIU, ANDI, ORI, XORI, SLTI, SLTIU, LUI,
            JAL, BGEZAL, BLTZAL: writes = 1'b1;
            default:             writes = 1'b0;
        endcase
    end

    assign dec.instr_code = code;
    assign dec.wr_en      = exec2 && writes;

    a_one_exec_phase: assert property (@(posedge clk) disable iff (!rst_n)
        !(exec1 && exec2))
        else $error("exec1 and exec2 high together");

endmodule

//--- decode_if.sv
// decode bus: decoded instruction fields from the decoder to datapath and controller
interface decode_if import mips_pkg::*; ();

    instr_code_t instr_code;
    logic [4:0]  rs_idx;
    logic [4:0]  rt_idx;
    logic [4:0]  dest_idx;      // rd, rt or the link register
    logic [4:0]  shamt;
    logic [31:0] imm;           // already extended
    logic [25:0] target;        // J/JAL word index
    logic        wr_en;         // only in exec2

    modport producer (
        output instr_code, rs_idx, rt_idx, dest_idx,
        output shamt, imm, target, wr_en
    );

    modport consumer (
        input instr_code, rs_idx, rt_idx, dest_idx,
        input shamt, imm, target, wr_en
    );

endinterface

//--- mips_pkg.sv
// mips package: instruction codes, phases, opcode and function values, reset constants
package mips_pkg;

    // instruction codes, numbered as in the original decoder, NOP for unknown words
    typedef enum logic [6:0] {
        NOP    = 7'd0,
        ADD    = 7'd1,  ADDI,  ADDIU, ADDU,  AND,   ANDI,
        DIV,   DIVU,  MFHI,  MFLO,  MTHI,  MTLO,
        MULT,  MULTU, OR,    ORI,   SLL,   SLLV,
        SLT,   SLTI,  SLTIU, SLTU,  SRA,   SRAV,
        SRL,   SRLV,  SUBU,  XOR,   XORI,
        BEQ    = 7'd30, BGEZ, BGEZAL, BGTZ, BLEZ, BLTZ,
        BLTZAL, BNE,  J,     JAL,   JALR,  JR,
        LB     = 7'd42, LBU,  LH,    LHU,   LUI,   LW,
        LWL,   LWR,   SB,    SH,    SW
    } instr_code_t;

    typedef enum logic [1:0] {
        FETCH = 2'd0,
        EXEC1 = 2'd1,
        EXEC2 = 2'd2
    } phase_t;

    // primary opcode field, bits 31:26
    localparam logic [5:0] OP_RTYPE  = 6'h00;
    localparam logic [5:0] OP_REGIMM = 6'h01;
    localparam logic [5:0] OP_J      = 6'h02;
    localparam logic [5:0] OP_JAL    = 6'h03;
    localparam logic [5:0] OP_BEQ    = 6'h04;
    localparam logic [5:0] OP_BNE    = 6'h05;
    localparam logic [5:0] OP_BLEZ   = 6'h06;
    localparam logic [5:0] OP_BGTZ   = 6'h07;
    localparam logic [5:0] OP_ADDI   = 6'h08;
    localparam logic [5:0] OP_ADDIU  = 6'h09;
    localparam logic [5:0] OP_SLTI   = 6'h0a;
    localparam logic [5:0] OP_SLTIU  = 6'h0b;
    localparam logic [5:0] OP_ANDI   = 6'h0c;
    localparam logic [5:0] OP_ORI    = 6'h0d;
    localparam logic [5:0] OP_XORI   = 6'h0e;
    localparam logic [5:0] OP_LUI    = 6'h0f;
    localparam logic [5:0] OP_LB     = 6'h20;
    localparam logic [5:0] OP_LH     = 6'h21;
    localparam logic [5:0] OP_LWL    = 6'h22;
    localparam logic [5:0] OP_LW     = 6'h23;
    localparam logic [5:0] OP_LBU    = 6'h24;
    localparam logic [5:0] OP_LHU    = 6'h25;
    localparam logic [5:0] OP_LWR    = 6'h26;
    localparam logic [5:0] OP_SB     = 6'h28;
    localparam logic [5:0] OP_SH     = 6'h29;
    localparam logic [5:0] OP_SW     = 6'h2b;

    // function field of R-type words, bits 5:0
    localparam logic [5:0] FN_SLL  = 6'h00, FN_SRL  = 6'h02, FN_SRA  = 6'h03;
    localparam logic [5:0] FN_SLLV = 6'h04, FN_SRLV = 6'h06, FN_SRAV = 6'h07;
    localparam logic [5:0] FN_JR   = 6'h08, FN_JALR = 6'h09;
    localparam logic [5:0] FN_MFHI = 6'h10, FN_MTHI = 6'h11, FN_MFLO = 6'h12, FN_MTLO = 6'h13;
    localparam logic [5:0] FN_MULT = 6'h18, FN_MULTU = 6'h19, FN_DIV = 6'h1a, FN_DIVU = 6'h1b;
    localparam logic [5:0] FN_ADD  = 6'h20, FN_ADDU = 6'h21, FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24, FN_OR   = 6'h25, FN_XOR  = 6'h26;
    localparam logic [5:0] FN_SLT  = 6'h2a, FN_SLTU = 6'h2b;

    // rt field selects the REGIMM branch
    localparam logic [4:0] RT_BLTZ   = 5'h00;
    localparam logic [4:0] RT_BGEZ   = 5'h01;
    localparam logic [4:0] RT_BLTZAL = 5'h10;
    localparam logic [4:0] RT_BGEZAL = 5'h11;

    localparam logic [31:0] RESET_PC = 32'h0000_0000;
    localparam logic [4:0]  LINK_REG = 5'd31;   // return address register

endpackage
